/* src/ldpc_code_pkg.sv */
`default_nettype none

package ldpc_code_pkg;

    // Lifting size and base matrix dimensions
    localparam int Z  = 16;
    localparam int KB = 4;
    localparam int MB = 4;

    // Counter width covers both KB and MB
    localparam int IDX_W = $clog2(((KB > MB) ? KB : MB) + 1);

    typedef logic [Z-1:0]     word_t;
    typedef logic signed [5:0] shift_t;
    typedef logic [IDX_W-1:0] blk_idx_t;

    // Marks a zero block in the base matrix
    localparam shift_t SHIFT_ABSENT = -6'sd1;

    // Rows are parity rows, columns are information columns
    // Entries are reduced mod Z where they are used
    localparam shift_t BASE_SHIFTS [MB][KB] = '{
        '{ 6'sd3,  -6'sd1, 6'sd17, 6'sd28},
        '{ 6'sd11, 6'sd5,  -6'sd1, 6'sd22},
        '{-6'sd1,  6'sd30, 6'sd7,  6'sd14},
        '{ 6'sd25, 6'sd9,  6'sd19, -6'sd1}
    };

    // Cyclic left rotation by a shift entry, mod Z
    function automatic word_t rotl_word(word_t w, shift_t s);
        int unsigned       amt;
        logic [2*Z-1:0]    dbl;
        amt = int'(s) % Z;
        dbl = {w, w} << amt;
        return dbl[2*Z-1:Z];
    endfunction

endpackage : ldpc_code_pkg

`default_nettype wire

/* src/ldpc_stream_pkg.sv */
`default_nettype none

package ldpc_stream_pkg;

    import ldpc_code_pkg::*;

    // What a beat carries between stages
    typedef enum logic [1:0] {
        KIND_INFO   = 2'd0,
        KIND_SYND   = 2'd1,
        KIND_PARITY = 2'd2
    } beat_kind_e;

    // last is set on the final parity beat of a frame only
    typedef struct packed {
        beat_kind_e kind;
        word_t      data;
        logic       last;
    } enc_beat_t;

endpackage : ldpc_stream_pkg

`default_nettype wire

/* src/pipe_slice.sv */
`default_nettype none

module pipe_slice #(
    parameter type T = logic
) (
    input  wire logic i_clock,
    input  wire logic i_reset,
    input  wire T     i_data,
    input  wire logic i_valid,
    output      logic o_ready,
    output      T     o_data,
    output      logic o_valid,
    input  wire logic i_ready
);

    T     skid_data;
    logic skid_valid;
    logic skid_valid_next;
    logic in_fire;
    logic out_free;

    assign in_fire  = i_valid && o_ready;
    // Main register may take new data this cycle
    assign out_free = !o_valid || i_ready;

    assign skid_valid_next = out_free ? 1'b0 : (skid_valid || in_fire);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_valid    <= 1'b0;
            skid_valid <= 1'b0;
            o_ready    <= 1'b0;
        end else begin
            if (out_free) begin
                o_valid <= skid_valid || in_fire;
            end
            skid_valid <= skid_valid_next;
            // Registered ready, low only while the skid is occupied
            o_ready    <= !skid_valid_next;
        end
    end

    always_ff @(posedge i_clock) begin
        if (out_free && (skid_valid || in_fire)) begin
            o_data <= skid_valid ? skid_data : i_data;
        end
        if (in_fire && !out_free) begin
            skid_data <= i_data;
        end
    end

endmodule : pipe_slice

`default_nettype wire

/* src/syndrome_acc.sv */
`default_nettype none

module syndrome_acc
    import ldpc_code_pkg::*, ldpc_stream_pkg::*;
(
    input  wire logic      i_clock,
    input  wire logic      i_reset,
    input  wire word_t     i_data,
    input  wire logic      i_valid,
    output      logic      o_ready,
    output      enc_beat_t o_beat,
    output      logic      o_valid,
    input  wire logic      i_ready
);

    typedef enum logic {
        ST_ACCEPT,
        ST_FLUSH
    } state_e;

    state_e   state;
    blk_idx_t blk_cnt;
    word_t    acc     [MB];
    word_t    acc_upd [MB];

    logic [$clog2(KB)-1:0] col_idx;
    logic [$clog2(MB)-1:0] row_idx;
    logic                  out_free;
    logic                  in_fire;

    assign col_idx = blk_cnt[$clog2(KB)-1:0];
    assign row_idx = blk_cnt[$clog2(MB)-1:0];

    assign out_free = !o_valid || i_ready;
    // No input during flush or while the output register is held
    assign o_ready  = (state == ST_ACCEPT) && out_free;
    assign in_fire  = i_valid && o_ready;

    // Rows with a present block in this column take the rotated word
    always_comb begin
        acc_upd = acc;
        for (int r = 0; r < MB; r++) begin
            if (BASE_SHIFTS[r][col_idx] != SHIFT_ABSENT) begin
                acc_upd[r] = acc[r] ^ rotl_word(i_data, BASE_SHIFTS[r][col_idx]);
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state   <= ST_ACCEPT;
            blk_cnt <= '0;
            o_valid <= 1'b0;
            acc     <= '{default: '0};
        end else begin
            case (state)
                ST_ACCEPT: begin
                    if (out_free) begin
                        o_valid <= in_fire;
                    end
                    if (in_fire) begin
                        acc <= acc_upd;
                        if (blk_cnt == blk_idx_t'(KB - 1)) begin
                            blk_cnt <= '0;
                            state   <= ST_FLUSH;
                        end else begin
                            blk_cnt <= blk_cnt + 1'b1;
                        end
                    end
                end
                ST_FLUSH: begin
                    if (out_free) begin
                        o_valid <= 1'b1;
                        if (blk_cnt == blk_idx_t'(MB - 1)) begin
                            // Frame done, start the next one clean
                            blk_cnt <= '0;
                            acc     <= '{default: '0};
                            state   <= ST_ACCEPT;
                        end else begin
                            blk_cnt <= blk_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= ST_ACCEPT;
                end
            endcase
        end
    end

    // Beat payload, held while the consumer stalls
    always_ff @(posedge i_clock) begin
        if (out_free) begin
            if (state == ST_FLUSH) begin
                o_beat.kind <= KIND_SYND;
                o_beat.data <= acc[row_idx];
                o_beat.last <= (blk_cnt == blk_idx_t'(MB - 1));
            end else begin
                o_beat.kind <= KIND_INFO;
                o_beat.data <= i_data;
                o_beat.last <= 1'b0;
            end
        end
    end

endmodule : syndrome_acc

`default_nettype wire

/* src/dual_diag_backsub.sv */
`default_nettype none

module dual_diag_backsub
    import ldpc_code_pkg::*, ldpc_stream_pkg::*;
(
    input  wire logic      i_clock,
    input  wire logic      i_reset,
    input  wire enc_beat_t i_beat,
    input  wire logic      i_valid,
    output      logic      o_ready,
    output      enc_beat_t o_beat,
    output      logic      o_valid,
    input  wire logic      i_ready
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PASSTHRU,
        ST_HALT
    } state_e;

    state_e    curr_state;
    state_e    next_state;
    enc_beat_t skid_beat;
    enc_beat_t conv_beat;
    enc_beat_t next_out_beat;
    enc_beat_t next_skid_beat;
    word_t     run_parity;
    logic      next_out_valid;
    logic      next_in_ready;
    logic      in_fire;

    assign in_fire = i_valid && o_ready;

    // Syndrome j becomes parity j = parity j-1 ^ syndrome j
    always_comb begin
        conv_beat = i_beat;
        if (i_beat.kind == KIND_SYND) begin
            conv_beat.kind = KIND_PARITY;
            conv_beat.data = run_parity ^ i_beat.data;
        end
    end

    always_comb begin
        next_state     = curr_state;
        next_out_beat  = o_beat;
        next_out_valid = o_valid;
        next_skid_beat = skid_beat;
        next_in_ready  = o_ready;
        case (curr_state)
            ST_IDLE: begin
                next_out_beat  = conv_beat;
                next_out_valid = in_fire;
                next_in_ready  = 1'b1;
                next_state     = in_fire ? ST_PASSTHRU : ST_IDLE;
            end
            ST_PASSTHRU: begin
                case ({i_ready, in_fire})
                    2'b11: next_out_beat = conv_beat;
                    2'b10: begin
                        next_out_valid = 1'b0;
                        next_state     = ST_IDLE;
                    end
                    2'b01: begin
                        // Output stalled with a beat in flight
                        next_skid_beat = conv_beat;
                        next_in_ready  = 1'b0;
                        next_state     = ST_HALT;
                    end
                    default: next_state = ST_PASSTHRU;
                endcase
            end
            ST_HALT: begin
                if (i_ready) begin
                    next_out_beat = skid_beat;
                    next_in_ready = 1'b1;
                    next_state    = ST_PASSTHRU;
                end
            end
            default: next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            curr_state <= ST_IDLE;
            o_valid    <= 1'b0;
            o_ready    <= 1'b0;
            run_parity <= '0;
        end else begin
            curr_state <= next_state;
            o_valid    <= next_out_valid;
            o_ready    <= next_in_ready;
            if (in_fire && (i_beat.kind == KIND_SYND)) begin
                run_parity <= i_beat.last ? '0 : conv_beat.data;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        o_beat    <= next_out_beat;
        skid_beat <= next_skid_beat;
    end

endmodule : dual_diag_backsub

`default_nettype wire

/* src/ldpc_encoder.sv */
`default_nettype none

module ldpc_encoder
    import ldpc_code_pkg::*, ldpc_stream_pkg::*;
(
    input  wire logic      i_clock,
    input  wire logic      i_reset,
    input  wire word_t     i_in_data,
    input  wire logic      i_in_valid,
    output      logic      o_in_ready,
    output      enc_beat_t o_out_beat,
    output      logic      o_out_valid,
    input  wire logic      i_out_ready
);

    // Input slice to syndrome accumulator
    word_t     word;
    logic      word_valid;
    logic      word_ready;

    // Syndrome accumulator to back-substitution
    enc_beat_t synd_beat;
    logic      synd_valid;
    logic      synd_ready;

    // Back-substitution to output slice
    enc_beat_t par_beat;
    logic      par_valid;
    logic      par_ready;

    pipe_slice #(.T(word_t)) i_in_slice (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_data  (i_in_data),
        .i_valid (i_in_valid),
        .o_ready (o_in_ready),
        .o_data  (word),
        .o_valid (word_valid),
        .i_ready (word_ready)
    );

    syndrome_acc i_syndrome_acc (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_data  (word),
        .i_valid (word_valid),
        .o_ready (word_ready),
        .o_beat  (synd_beat),
        .o_valid (synd_valid),
        .i_ready (synd_ready)
    );

    dual_diag_backsub i_backsub (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_beat  (synd_beat),
        .i_valid (synd_valid),
        .o_ready (synd_ready),
        .o_beat  (par_beat),
        .o_valid (par_valid),
        .i_ready (par_ready)
    );

    pipe_slice #(.T(enc_beat_t)) i_out_slice (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_data  (par_beat),
        .i_valid (par_valid),
        .o_ready (par_ready),
        .o_data  (o_out_beat),
        .o_valid (o_out_valid),
        .i_ready (i_out_ready)
    );

endmodule : ldpc_encoder

`default_nettype wire

/* tb/ldpc_encoder_chk.sv */
`default_nettype none

module ldpc_encoder_chk
    import ldpc_stream_pkg::*;
(
    input wire logic      i_clock,
    input wire logic      i_reset,
    input wire enc_beat_t o_out_beat,
    input wire logic      o_out_valid,
    input wire logic      i_out_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    // Read by the testbench at the end of the run
    int   fail_count = 0;
    logic clock_seen = 1'b0;
    // Between the first and the last parity beat of a frame
    logic mid_parity;

    always_ff @(posedge i_clock) begin
        clock_seen <= 1'b1;
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            mid_parity <= 1'b0;
        end else if (o_out_valid && i_out_ready) begin
            mid_parity <= (o_out_beat.kind == KIND_PARITY) && !o_out_beat.last;
        end
    end

    // Output valid is low on every edge that follows a reset edge
    a_no_valid_in_reset: assert property (@(posedge i_clock)
        clock_seen && $past(i_reset) |-> !o_out_valid)
    else begin
        fail_count++;
        $error("output valid high while in reset");
    end

    a_beat_stable: assert property (@(posedge i_clock) disable iff (i_reset)
        o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out_beat))
    else begin
        fail_count++;
        $error("output beat changed or dropped while stalled");
    end

    a_last_on_parity: assert property (@(posedge i_clock) disable iff (i_reset)
        o_out_valid && o_out_beat.last |-> o_out_beat.kind == KIND_PARITY)
    else begin
        fail_count++;
        $error("last set on a beat that is not parity");
    end

    // Once parity starts, the frame carries parity up to its last beat
    a_no_synd_after_parity: assert property (@(posedge i_clock) disable iff (i_reset)
        clock_seen && mid_parity && o_out_valid |-> o_out_beat.kind == KIND_PARITY)
    else begin
        fail_count++;
        $error("beat after a parity beat was not parity");
    end

endmodule : ldpc_encoder_chk

bind ldpc_encoder ldpc_encoder_chk i_chk (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .o_out_beat  (o_out_beat),
    .o_out_valid (o_out_valid),
    .i_out_ready (i_out_ready)
);

`default_nettype wire

/* tb/ldpc_encoder_tb.sv */
`default_nettype none

module ldpc_encoder_tb
    import ldpc_code_pkg::*, ldpc_stream_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAMES          = 40;
    localparam int BEATS           = KB + MB;
    localparam int TOTAL_BEATS     = FRAMES * BEATS;
    localparam int RESET_CYCLES    = 4;
    localparam int WATCHDOG_CYCLES = FRAMES * BEATS * 20;

    logic      i_clock;
    logic      i_reset;
    word_t     i_in_data;
    logic      i_in_valid;
    logic      o_in_ready;
    enc_beat_t o_out_beat;
    logic      o_out_valid;
    logic      i_out_ready;

    enc_beat_t exp_q [$];
    int        value_errors    = 0;
    int        protocol_errors = 0;
    int        rx_count        = 0;

    ldpc_encoder i_ldpc_encoder (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_in_data   (i_in_data),
        .i_in_valid  (i_in_valid),
        .o_in_ready  (o_in_ready),
        .o_out_beat  (o_out_beat),
        .o_out_valid (o_out_valid),
        .i_out_ready (i_out_ready)
    );

    initial begin
        i_clock = 1'b0;
        forever #5 i_clock = ~i_clock;
    end

    // Bit i of the word lands on bit (i + amt) mod Z
    function automatic word_t rotate_left(input word_t w, input int amt);
        word_t r;
        for (int i = 0; i < Z; i++) begin
            r[(i + amt) % Z] = w[i];
        end
        return r;
    endfunction

    function automatic enc_beat_t make_beat(input beat_kind_e kind, input word_t data,
                                            input logic last);
        enc_beat_t b;
        b.kind = kind;
        b.data = data;
        b.last = last;
        return b;
    endfunction

    // Syndromes from the base table, then the staircase running XOR
    task automatic queue_parity(input word_t words [KB]);
        word_t synd;
        word_t par;
        par = '0;
        for (int j = 0; j < MB; j++) begin
            synd = '0;
            for (int k = 0; k < KB; k++) begin
                if (BASE_SHIFTS[j][k] >= 0) begin
                    synd ^= rotate_left(words[k], int'(BASE_SHIFTS[j][k]) % Z);
                end
            end
            par ^= synd;
            exp_q.push_back(make_beat(KIND_PARITY, par, j == MB - 1));
        end
    endtask

    // Called at a falling edge, returns at the falling edge after the transfer
    task automatic send_word(input word_t w);
        int gap;
        gap = ($urandom % 4 == 0) ? 1 + $urandom % 4 : 0;
        repeat (gap) @(negedge i_clock);
        i_in_data  = w;
        i_in_valid = 1'b1;
        // Ready is registered, so its value here holds until the next rising edge
        while (!o_in_ready) @(negedge i_clock);
        @(negedge i_clock);
        i_in_valid = 1'b0;
    endtask

    task automatic check_word(input word_t got, input word_t exp, input int beat_no);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %0t ns: beat %0d data %h, expected %h", $time, beat_no, got, exp);
        end
    endtask

    task automatic check_kind(input beat_kind_e got, input beat_kind_e exp, input int beat_no);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %0t ns: beat %0d kind %s, expected %s",
                     $time, beat_no, got.name(), exp.name());
        end
    endtask

    task automatic check_last(input logic got, input logic exp, input int beat_no);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %0t ns: beat %0d last %b, expected %b", $time, beat_no, got, exp);
        end
    endtask

    // Output side: random stalls, and a compare on every transfer
    initial begin
        int        low_left;
        enc_beat_t exp;
        low_left    = 0;
        i_out_ready = 1'b0;
        forever begin
            @(negedge i_clock);
            if (low_left > 0) begin
                i_out_ready = 1'b0;
                low_left--;
            end else if ($urandom % 5 == 0) begin
                i_out_ready = 1'b0;
                low_left    = $urandom % 6;
            end else begin
                i_out_ready = 1'b1;
            end
            if (!i_reset && o_out_valid && i_out_ready) begin
                if (exp_q.size() == 0) begin
                    protocol_errors++;
                    $display("Output beat at %0t ns arrived with no beat expected", $time);
                end else begin
                    exp = exp_q.pop_front();
                    check_kind(o_out_beat.kind, exp.kind, rx_count % BEATS);
                    check_word(o_out_beat.data, exp.data, rx_count % BEATS);
                    check_last(o_out_beat.last, exp.last, rx_count % BEATS);
                end
                rx_count++;
            end
        end
    end

    initial begin
        word_t words [KB];
        int    assert_errors;
        i_reset    = 1'b1;
        i_in_valid = 1'b0;
        i_in_data  = '0;
        void'($urandom(98));
        repeat (RESET_CYCLES) @(negedge i_clock);
        i_reset = 1'b0;

        // Nothing may leave the encoder before the first word
        repeat (5) begin
            @(negedge i_clock);
            if (o_out_valid !== 1'b0) begin
                protocol_errors++;
                $display("Output valid was high at %0t ns before any input", $time);
            end
        end

        for (int f = 0; f < FRAMES; f++) begin
            for (int k = 0; k < KB; k++) begin
                words[k] = word_t'($urandom);
                send_word(words[k]);
                exp_q.push_back(make_beat(KIND_INFO, words[k], 1'b0));
            end
            queue_parity(words);
        end

        while (rx_count < TOTAL_BEATS) @(negedge i_clock);
        // A few more cycles to catch stray beats
        repeat (20) @(negedge i_clock);
        if (exp_q.size() != 0 || rx_count != TOTAL_BEATS) begin
            protocol_errors++;
            $display("Received %0d beats, expected %0d", rx_count, TOTAL_BEATS);
        end

        assert_errors = i_ldpc_encoder.i_chk.fail_count;
        $display("Errors: %0d value, %0d protocol, %0d assertion",
                 value_errors, protocol_errors, assert_errors);
        if (value_errors == 0 && protocol_errors == 0 && assert_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge i_clock);
        $display("Timeout after %0d cycles with %0d of %0d beats received",
                 RESET_CYCLES + WATCHDOG_CYCLES, rx_count, TOTAL_BEATS);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule : ldpc_encoder_tb

`default_nettype wire

/* tb.f */
src/ldpc_code_pkg.sv
src/ldpc_stream_pkg.sv
src/pipe_slice.sv
src/syndrome_acc.sv
src/dual_diag_backsub.sv
src/ldpc_encoder.sv
tb/ldpc_encoder_chk.sv
tb/ldpc_encoder_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= ldpc_encoder_tb
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= 1ns/1ps
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0
RUN_ARGS   ?= +verilator+error+limit+1000
PASS_LINE  ?= PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qxF "$(PASS_LINE)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, pass line not found in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
